/* wbi_pkg.sv */
/*
 * Shared widths, slave ids, address map and bus word types for the
 * Wishbone shared-bus interconnect. Modules pull these in with a
 * wildcard import in their header.
 */

package wbi_pkg;

  // ------------------------------------------------------------------
  // Bus widths and port counts
  // ------------------------------------------------------------------
  localparam int WB_DAT_W = 32;
  localparam int WB_ADR_W = 32;
  localparam int WB_SEL_W = 4;

  // Masters m0 host, m1 instruction fetch, m2 data access
  localparam int NUM_MST = 3;
  // Slaves s0 memory, s1 peripherals, s2 ADC, s3 pin-mux
  localparam int NUM_SLV = 4;

  typedef logic [$clog2(NUM_MST)-1:0] mst_idx_t;
  typedef logic [$clog2(NUM_SLV)-1:0] tid_t;

  // Target slave ids
  localparam tid_t TID_MEM    = 2'd0;
  localparam tid_t TID_PERIPH = 2'd1;
  localparam tid_t TID_ADC    = 2'd2;
  localparam tid_t TID_PINMUX = 2'd3;

  // ------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------
  // 0x0000_0000 .. 0x0FFF_FFFF memory region
  localparam logic [3:0]  MEM_REGION_PFX = 4'h0;
  // 0x1000_xxxx memory controller registers
  localparam logic [15:0] MEM_REG_PFX    = 16'h1000;
  // 0x1001_xxxx peripheral block
  localparam logic [15:0] PERIPH_PFX     = 16'h1001;
  // 0x1002_xxxx ADC registers
  localparam logic [15:0] ADC_PFX        = 16'h1002;
  // 0x1003_xxxx pin-mux registers
  localparam logic [15:0] PINMUX_PFX     = 16'h1003;
  // Anything else lands on memory

  // ------------------------------------------------------------------
  // Bus words
  // ------------------------------------------------------------------
  // Request from a master, 71 bits
  typedef struct packed {
    logic [WB_DAT_W-1:0] dat;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_SEL_W-1:0] sel;
    logic                we;
    logic                cyc;
    logic                stb;
  } wb_req_t;

  // Read data and ack back toward a master, 33 bits
  typedef struct packed {
    logic [WB_DAT_W-1:0] dat;
    logic                ack;
  } wb_rsp_t;

  // Decoded request carrying its target id, 73 bits
  typedef struct packed {
    wb_req_t req;
    tid_t    tid;
  } wb_slv_req_t;

endpackage

/* wbi_rr_arb.sv */
/*
 * Round-robin arbiter for the shared bus. The grant is registered and
 * only moves away from the owner once the owner stops requesting.
 */

`timescale 1ns/1ps

module wbi_rr_arb
  import wbi_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [NUM_MST-1:0] req_i,
  output mst_idx_t           gnt_o
);

  mst_idx_t gnt_q;
  mst_idx_t gnt_d;

  // ------------------------------------------------------------------
  // Next owner search
  // ------------------------------------------------------------------
  always_comb begin
    int unsigned idx;
    gnt_d = gnt_q;
    idx   = 0;
    // Owner keeps the bus while it still requests
    if (!req_i[gnt_q]) begin
      // Walk backwards so the nearest requester after the owner wins
      for (int k = NUM_MST - 1; k >= 1; k--) begin
        idx = (int'(gnt_q) + k) % NUM_MST;
        if (req_i[idx]) begin
          gnt_d = mst_idx_t'(idx);
        end
      end
    end
  end

  // Grant register, master 0 owns the bus out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  assign gnt_o = gnt_q;

  // Grant never points past the last master
  a_gnt_range: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    int'(gnt_q) < NUM_MST
  ) else $error("arbiter grant %0d out of range", gnt_q);

endmodule

/* wbi_master_mux.sv */
/*
 * Master side multiplexer. Puts the granted master's request on the
 * shared bus, returns the bus response to that master alone and builds
 * the request vector the arbiter works from.
 */

`timescale 1ns/1ps

module wbi_master_mux
  import wbi_pkg::*;
(
  input  mst_idx_t           gnt_i,
  input  wb_req_t            m_req_i [NUM_MST],
  output wb_rsp_t            m_rsp_o [NUM_MST],
  output wb_req_t            bus_req_o,
  input  wb_rsp_t            bus_rsp_i,
  output logic [NUM_MST-1:0] arb_req_o
);

  // ------------------------------------------------------------------
  // Request select
  // ------------------------------------------------------------------
  always_comb begin
    bus_req_o = '0;
    for (int i = 0; i < NUM_MST; i++) begin
      if (gnt_i == mst_idx_t'(i)) begin
        bus_req_o = m_req_i[i];
      end
    end
  end

  // ------------------------------------------------------------------
  // Response fan-out and arbiter requests
  // ------------------------------------------------------------------
  for (genvar i = 0; i < NUM_MST; i++) begin : g_mst
    // Masters without the grant see an idle bus
    assign m_rsp_o[i] = (gnt_i == mst_idx_t'(i)) ? bus_rsp_i : '0;

    // A strobe that is being acked no longer counts as a request
    // so the grant can rotate on the ack cycle
    assign arb_req_o[i] = m_req_i[i].stb & ~m_rsp_o[i].ack;
  end

endmodule

/* wbi_addr_decode.sv */
/*
 * Address decoder for the granted request. Looks the address up in the
 * map to find the target slave and word-aligns it.
 */

`timescale 1ns/1ps

module wbi_addr_decode
  import wbi_pkg::*;
(
  input  wb_req_t     bus_req_i,
  output wb_slv_req_t slv_req_o
);

  logic [15:0] adr_hi;

  assign adr_hi = bus_req_i.adr[WB_ADR_W-1 -: 16];

  always_comb begin
    slv_req_o.req = bus_req_i;
    // Word aligned access only
    slv_req_o.req.adr[1:0] = 2'b00;

    // Memory region has priority over the register windows
    if (bus_req_i.adr[WB_ADR_W-1 -: 4] == MEM_REGION_PFX) begin
      slv_req_o.tid = TID_MEM;
    end else begin
      case (adr_hi)
        MEM_REG_PFX: slv_req_o.tid = TID_MEM;
        PERIPH_PFX:  slv_req_o.tid = TID_PERIPH;
        ADC_PFX:     slv_req_o.tid = TID_ADC;
        PINMUX_PFX:  slv_req_o.tid = TID_PINMUX;
        // Holes in the map default to memory
        default:     slv_req_o.tid = TID_MEM;
      endcase
    end
  end

endmodule

/* wbi_stage.sv */
/*
 * Staging registers between the master side and the slave side of the
 * bus. One request is held toward the slaves until acked, and the ack
 * and read data are registered on the way back.
 */

`timescale 1ns/1ps

module wbi_stage
  import wbi_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  // Decoded request from the granted master
  input  wb_slv_req_t m_req_i,
  output wb_rsp_t     m_rsp_o,
  // Held request toward the slave router
  output wb_slv_req_t s_req_o,
  input  wb_rsp_t     s_rsp_i
);

  wb_slv_req_t req_q;
  wb_rsp_t     rsp_q;
  logic        accept;
  logic        done;

  // ------------------------------------------------------------------
  // Handshake control
  // ------------------------------------------------------------------
  // Slave has answered the held request
  assign done = req_q.req.stb & s_rsp_i.ack;

  // New request only when nothing is held and the previous ack
  // has left the response register
  assign accept = ~req_q.req.stb & ~rsp_q.ack & m_req_i.req.stb;

  // ------------------------------------------------------------------
  // Request register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= '0;
    end else if (done) begin
      // Drop strobe and park the bus with everything low
      req_q <= '0;
    end else if (accept) begin
      req_q <= m_req_i;
    end
  end

  // ------------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else begin
      // Ack pulses for one cycle since the strobe drops on the same edge
      rsp_q.ack <= done;
      if (done) begin
        rsp_q.dat <= s_rsp_i.dat;
      end
    end
  end

  assign s_req_o = req_q;
  assign m_rsp_o = rsp_q;

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  // Slave back-pressure holds the request word steady
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (s_req_o.req.stb && !s_rsp_i.ack) |=> $stable(s_req_o)
  ) else $error("staged request changed while waiting for slave ack");

  // Master ack is a single cycle pulse
  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    m_rsp_o.ack |=> !m_rsp_o.ack
  ) else $error("master ack held for two cycles");

endmodule

/* wbi_slave_route.sv */
/*
 * Slave side router. Steers the staged request to the slave named by
 * its target id, trims each slave's address and picks that slave's
 * response for the return path.
 */

`timescale 1ns/1ps

module wbi_slave_route
  import wbi_pkg::*;
#(
  // Address bits delivered to the ADC and pin-mux slaves
  parameter int NARROW_ADR_W = 8
) (
  input  wb_slv_req_t s_req_i,
  output wb_rsp_t     s_rsp_o,
  output wb_req_t     slv_req_o [NUM_SLV],
  input  wb_rsp_t     slv_rsp_i [NUM_SLV]
);

  // Keeps the low NARROW_ADR_W address bits
  localparam logic [WB_ADR_W-1:0] NARROW_MASK =
    {WB_ADR_W{1'b1}} >> (WB_ADR_W - NARROW_ADR_W);

  // ------------------------------------------------------------------
  // Request steering and response select
  // ------------------------------------------------------------------
  always_comb begin
    s_rsp_o = '0;
    for (int k = 0; k < NUM_SLV; k++) begin
      // Slaves that are not addressed see a quiet bus
      slv_req_o[k] = '0;
      if (s_req_i.tid == tid_t'(k)) begin
        slv_req_o[k] = s_req_i.req;
        s_rsp_o      = slv_rsp_i[k];
      end
    end

    // Peripheral block decodes within its 256 MB window
    slv_req_o[TID_PERIPH].adr[WB_ADR_W-1 -: 4] = 4'h0;

    // Register slaves only need a short offset
    slv_req_o[TID_ADC].adr    = slv_req_o[TID_ADC].adr & NARROW_MASK;
    slv_req_o[TID_PINMUX].adr = slv_req_o[TID_PINMUX].adr & NARROW_MASK;
  end

endmodule

/* wb_interconnect.sv */
/*
 * Wishbone shared-bus interconnect top, three masters to four slaves.
 * Packs the flat Wishbone ports into bus words and chains arbiter,
 * master mux, decoder, staging registers and slave router.
 */

`timescale 1ns/1ps

module wb_interconnect
  import wbi_pkg::*;
#(
  parameter int NARROW_ADR_W = 8
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Master 0, external host
  input  logic [WB_DAT_W-1:0]     m0_wbd_dat_i,
  input  logic [WB_ADR_W-1:0]     m0_wbd_adr_i,
  input  logic [WB_SEL_W-1:0]     m0_wbd_sel_i,
  input  logic                    m0_wbd_we_i,
  input  logic                    m0_wbd_cyc_i,
  input  logic                    m0_wbd_stb_i,
  output logic [WB_DAT_W-1:0]     m0_wbd_dat_o,
  output logic                    m0_wbd_ack_o,
  // Master 1, instruction fetch
  input  logic [WB_DAT_W-1:0]     m1_wbd_dat_i,
  input  logic [WB_ADR_W-1:0]     m1_wbd_adr_i,
  input  logic [WB_SEL_W-1:0]     m1_wbd_sel_i,
  input  logic                    m1_wbd_we_i,
  input  logic                    m1_wbd_cyc_i,
  input  logic                    m1_wbd_stb_i,
  output logic [WB_DAT_W-1:0]     m1_wbd_dat_o,
  output logic                    m1_wbd_ack_o,
  // Master 2, data access
  input  logic [WB_DAT_W-1:0]     m2_wbd_dat_i,
  input  logic [WB_ADR_W-1:0]     m2_wbd_adr_i,
  input  logic [WB_SEL_W-1:0]     m2_wbd_sel_i,
  input  logic                    m2_wbd_we_i,
  input  logic                    m2_wbd_cyc_i,
  input  logic                    m2_wbd_stb_i,
  output logic [WB_DAT_W-1:0]     m2_wbd_dat_o,
  output logic                    m2_wbd_ack_o,
  // Slave 0, memory
  input  logic [WB_DAT_W-1:0]     s0_wbd_dat_i,
  input  logic                    s0_wbd_ack_i,
  output logic [WB_DAT_W-1:0]     s0_wbd_dat_o,
  output logic [WB_ADR_W-1:0]     s0_wbd_adr_o,
  output logic [WB_SEL_W-1:0]     s0_wbd_sel_o,
  output logic                    s0_wbd_we_o,
  output logic                    s0_wbd_cyc_o,
  output logic                    s0_wbd_stb_o,
  // Slave 1, peripheral block
  input  logic [WB_DAT_W-1:0]     s1_wbd_dat_i,
  input  logic                    s1_wbd_ack_i,
  output logic [WB_DAT_W-1:0]     s1_wbd_dat_o,
  output logic [WB_ADR_W-1:0]     s1_wbd_adr_o,
  output logic [WB_SEL_W-1:0]     s1_wbd_sel_o,
  output logic                    s1_wbd_we_o,
  output logic                    s1_wbd_cyc_o,
  output logic                    s1_wbd_stb_o,
  // Slave 2, ADC registers
  input  logic [WB_DAT_W-1:0]     s2_wbd_dat_i,
  input  logic                    s2_wbd_ack_i,
  output logic [WB_DAT_W-1:0]     s2_wbd_dat_o,
  output logic [NARROW_ADR_W-1:0] s2_wbd_adr_o,
  output logic [WB_SEL_W-1:0]     s2_wbd_sel_o,
  output logic                    s2_wbd_we_o,
  output logic                    s2_wbd_cyc_o,
  output logic                    s2_wbd_stb_o,
  // Slave 3, pin-mux registers
  input  logic [WB_DAT_W-1:0]     s3_wbd_dat_i,
  input  logic                    s3_wbd_ack_i,
  output logic [WB_DAT_W-1:0]     s3_wbd_dat_o,
  output logic [NARROW_ADR_W-1:0] s3_wbd_adr_o,
  output logic [WB_SEL_W-1:0]     s3_wbd_sel_o,
  output logic                    s3_wbd_we_o,
  output logic                    s3_wbd_cyc_o,
  output logic                    s3_wbd_stb_o
);

  wb_req_t            m_req [NUM_MST];
  wb_rsp_t            m_rsp [NUM_MST];
  wb_req_t            bus_req;
  wb_rsp_t            bus_rsp;
  wb_slv_req_t        dec_req;
  wb_slv_req_t        stg_req;
  wb_rsp_t            stg_rsp;
  wb_req_t            slv_req [NUM_SLV];
  wb_rsp_t            slv_rsp [NUM_SLV];
  logic [NUM_MST-1:0] arb_req;
  mst_idx_t           gnt;

  // ------------------------------------------------------------------
  // Master port packing
  // ------------------------------------------------------------------
  assign m_req[0] = '{dat: m0_wbd_dat_i, adr: m0_wbd_adr_i, sel: m0_wbd_sel_i,
                      we: m0_wbd_we_i, cyc: m0_wbd_cyc_i, stb: m0_wbd_stb_i};
  assign m_req[1] = '{dat: m1_wbd_dat_i, adr: m1_wbd_adr_i, sel: m1_wbd_sel_i,
                      we: m1_wbd_we_i, cyc: m1_wbd_cyc_i, stb: m1_wbd_stb_i};
  assign m_req[2] = '{dat: m2_wbd_dat_i, adr: m2_wbd_adr_i, sel: m2_wbd_sel_i,
                      we: m2_wbd_we_i, cyc: m2_wbd_cyc_i, stb: m2_wbd_stb_i};

  assign m0_wbd_dat_o = m_rsp[0].dat;
  assign m0_wbd_ack_o = m_rsp[0].ack;
  assign m1_wbd_dat_o = m_rsp[1].dat;
  assign m1_wbd_ack_o = m_rsp[1].ack;
  assign m2_wbd_dat_o = m_rsp[2].dat;
  assign m2_wbd_ack_o = m_rsp[2].ack;

  // ------------------------------------------------------------------
  // Bus datapath
  // ------------------------------------------------------------------
  wbi_rr_arb u_arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (arb_req),
    .gnt_o    (gnt)
  );

  wbi_master_mux u_mmux (
    .gnt_i     (gnt),
    .m_req_i   (m_req),
    .m_rsp_o   (m_rsp),
    .bus_req_o (bus_req),
    .bus_rsp_i (bus_rsp),
    .arb_req_o (arb_req)
  );

  wbi_addr_decode u_dec (
    .bus_req_i (bus_req),
    .slv_req_o (dec_req)
  );

  // Breaks the path between master and slave timing domains
  wbi_stage u_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .m_req_i  (dec_req),
    .m_rsp_o  (bus_rsp),
    .s_req_o  (stg_req),
    .s_rsp_i  (stg_rsp)
  );

  wbi_slave_route #(
    .NARROW_ADR_W (NARROW_ADR_W)
  ) u_route (
    .s_req_i   (stg_req),
    .s_rsp_o   (stg_rsp),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp)
  );

  // ------------------------------------------------------------------
  // Slave port packing
  // ------------------------------------------------------------------
  assign slv_rsp[0] = '{dat: s0_wbd_dat_i, ack: s0_wbd_ack_i};
  assign slv_rsp[1] = '{dat: s1_wbd_dat_i, ack: s1_wbd_ack_i};
  assign slv_rsp[2] = '{dat: s2_wbd_dat_i, ack: s2_wbd_ack_i};
  assign slv_rsp[3] = '{dat: s3_wbd_dat_i, ack: s3_wbd_ack_i};

  assign s0_wbd_dat_o = slv_req[0].dat;
  assign s0_wbd_adr_o = slv_req[0].adr;
  assign s0_wbd_sel_o = slv_req[0].sel;
  assign s0_wbd_we_o  = slv_req[0].we;
  assign s0_wbd_cyc_o = slv_req[0].cyc;
  assign s0_wbd_stb_o = slv_req[0].stb;

  assign s1_wbd_dat_o = slv_req[1].dat;
  assign s1_wbd_adr_o = slv_req[1].adr;
  assign s1_wbd_sel_o = slv_req[1].sel;
  assign s1_wbd_we_o  = slv_req[1].we;
  assign s1_wbd_cyc_o = slv_req[1].cyc;
  assign s1_wbd_stb_o = slv_req[1].stb;

  // Router already cleared the upper bits of the narrow slaves
  assign s2_wbd_dat_o = slv_req[2].dat;
  assign s2_wbd_adr_o = slv_req[2].adr[NARROW_ADR_W-1:0];
  assign s2_wbd_sel_o = slv_req[2].sel;
  assign s2_wbd_we_o  = slv_req[2].we;
  assign s2_wbd_cyc_o = slv_req[2].cyc;
  assign s2_wbd_stb_o = slv_req[2].stb;

  assign s3_wbd_dat_o = slv_req[3].dat;
  assign s3_wbd_adr_o = slv_req[3].adr[NARROW_ADR_W-1:0];
  assign s3_wbd_sel_o = slv_req[3].sel;
  assign s3_wbd_we_o  = slv_req[3].we;
  assign s3_wbd_cyc_o = slv_req[3].cyc;
  assign s3_wbd_stb_o = slv_req[3].stb;

endmodule

/* tb_clk_gen.sv */
/*
 * Testbench clock and reset source. Free running clock and an active
 * low reset held for a set number of cycles, released on a falling edge.
 */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset low from time zero, let go away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* tb_wb_interconnect.sv */
/*
 * Testbench for the Wishbone shared-bus interconnect. Three random
 * master streams and four slave models with random wait states, checked
 * against a reference decode of the address map on every completion.
 */

`timescale 1ns/1ps

module tb_wb_interconnect
  import wbi_pkg::*;
();

  localparam int          NARROW_W    = 8;
  localparam int          TXN_PER_MST = 40;
  // First 20 of each stream are issued back to back
  localparam int          BURST_TXN   = 20;
  localparam int          TIMEOUT_CYC = NUM_MST * TXN_PER_MST * (2 + 3 + 3) * 2;
  localparam int unsigned SEED        = 32'h0cc6_afd8;

  // Expected slave id and slave side address
  typedef struct packed {
    logic [1:0]  tid;
    logic [31:0] adr;
  } slv_exp_t;

  // One transfer as seen on the slave side
  typedef struct packed {
    slv_exp_t    slv;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
  } txn_t;

  logic                clk;
  logic                arst_n;
  wb_req_t             m_req [NUM_MST];
  wire  [31:0]         m_dat [NUM_MST];
  wire                 m_ack [NUM_MST];
  wire  [31:0]         s_dat [NUM_SLV];
  wire  [31:0]         s_adr [NUM_SLV];
  wire  [NARROW_W-1:0] s2_adr;
  wire  [NARROW_W-1:0] s3_adr;
  wire  [3:0]          s_sel [NUM_SLV];
  wire                 s_we  [NUM_SLV];
  wire                 s_cyc [NUM_SLV];
  wire                 s_stb [NUM_SLV];
  logic [31:0]         s_rdat [NUM_SLV];
  logic                s_ack  [NUM_SLV];

  // Scoreboard state
  txn_t cur [NUM_MST];
  txn_t slv_log [$];
  int   issued_cnt [NUM_MST];
  int   done_cnt [NUM_MST];
  int   wins [NUM_MST][NUM_MST];
  int   masters_done;
  int   comp_total;
  int   checks;
  int   errors;
  int   cycles;

  tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(2)) u_clk (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  wb_interconnect #(.NARROW_ADR_W(NARROW_W)) UUT (
    .clk_i        (clk),            .arst_n_i     (arst_n),
    .m0_wbd_dat_i (m_req[0].dat),   .m0_wbd_adr_i (m_req[0].adr),
    .m0_wbd_sel_i (m_req[0].sel),   .m0_wbd_we_i  (m_req[0].we),
    .m0_wbd_cyc_i (m_req[0].cyc),   .m0_wbd_stb_i (m_req[0].stb),
    .m0_wbd_dat_o (m_dat[0]),       .m0_wbd_ack_o (m_ack[0]),
    .m1_wbd_dat_i (m_req[1].dat),   .m1_wbd_adr_i (m_req[1].adr),
    .m1_wbd_sel_i (m_req[1].sel),   .m1_wbd_we_i  (m_req[1].we),
    .m1_wbd_cyc_i (m_req[1].cyc),   .m1_wbd_stb_i (m_req[1].stb),
    .m1_wbd_dat_o (m_dat[1]),       .m1_wbd_ack_o (m_ack[1]),
    .m2_wbd_dat_i (m_req[2].dat),   .m2_wbd_adr_i (m_req[2].adr),
    .m2_wbd_sel_i (m_req[2].sel),   .m2_wbd_we_i  (m_req[2].we),
    .m2_wbd_cyc_i (m_req[2].cyc),   .m2_wbd_stb_i (m_req[2].stb),
    .m2_wbd_dat_o (m_dat[2]),       .m2_wbd_ack_o (m_ack[2]),
    .s0_wbd_dat_i (s_rdat[0]),      .s0_wbd_ack_i (s_ack[0]),
    .s0_wbd_dat_o (s_dat[0]),       .s0_wbd_adr_o (s_adr[0]),
    .s0_wbd_sel_o (s_sel[0]),       .s0_wbd_we_o  (s_we[0]),
    .s0_wbd_cyc_o (s_cyc[0]),       .s0_wbd_stb_o (s_stb[0]),
    .s1_wbd_dat_i (s_rdat[1]),      .s1_wbd_ack_i (s_ack[1]),
    .s1_wbd_dat_o (s_dat[1]),       .s1_wbd_adr_o (s_adr[1]),
    .s1_wbd_sel_o (s_sel[1]),       .s1_wbd_we_o  (s_we[1]),
    .s1_wbd_cyc_o (s_cyc[1]),       .s1_wbd_stb_o (s_stb[1]),
    .s2_wbd_dat_i (s_rdat[2]),      .s2_wbd_ack_i (s_ack[2]),
    .s2_wbd_dat_o (s_dat[2]),       .s2_wbd_adr_o (s2_adr),
    .s2_wbd_sel_o (s_sel[2]),       .s2_wbd_we_o  (s_we[2]),
    .s2_wbd_cyc_o (s_cyc[2]),       .s2_wbd_stb_o (s_stb[2]),
    .s3_wbd_dat_i (s_rdat[3]),      .s3_wbd_ack_i (s_ack[3]),
    .s3_wbd_dat_o (s_dat[3]),       .s3_wbd_adr_o (s3_adr),
    .s3_wbd_sel_o (s_sel[3]),       .s3_wbd_we_o  (s_we[3]),
    .s3_wbd_cyc_o (s_cyc[3]),       .s3_wbd_stb_o (s_stb[3])
  );

  // Narrow slaves seen as zero extended words
  assign s_adr[2] = 32'(s2_adr);
  assign s_adr[3] = 32'(s3_adr);

  // --------------------------------------------------------------------
  // Reference model and check helpers
  // --------------------------------------------------------------------
  function automatic slv_exp_t expected_slave(input logic [31:0] adr);
    slv_exp_t e;
    e.adr = {adr[31:2], 2'b00};
    e.tid = 2'd0;
    // 0x0xxx_xxxx is always memory, then the 64 KB windows
    if (adr[31:28] != 4'h0) begin
      case (adr[31:16])
        16'h1001: e.tid = 2'd1;
        16'h1002: e.tid = 2'd2;
        16'h1003: e.tid = 2'd3;
        default:  e.tid = 2'd0;
      endcase
    end
    if (e.tid == 2'd1) begin
      e.adr[31:28] = 4'h0;
    end else if (e.tid >= 2'd2) begin
      e.adr = e.adr & ((32'h1 << NARROW_W) - 32'h1);
    end
    return e;
  endfunction

  // Spread over every window plus unmapped space
  function automatic logic [31:0] random_addr();
    logic [15:0] lo;
    lo = 16'($urandom);
    case ($urandom % 6)
      0:       return {4'h0, 28'($urandom)};
      1:       return {16'h1000, lo};
      2:       return {16'h1001, lo};
      3:       return {16'h1002, lo};
      4:       return {16'h1003, lo};
      default: return {16'h1004 + 16'($urandom % 32'hEFFC), lo};
    endcase
  endfunction

  function automatic txn_t slave_view(input int k);
    return '{slv: '{tid: 2'(k), adr: s_adr[k]}, dat: s_dat[k], sel: s_sel[k], we: s_we[k]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_that(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  // --------------------------------------------------------------------
  // Masters and slaves
  // --------------------------------------------------------------------
  task automatic run_master(input int id);
    wb_req_t r;
    txn_t    t;
    @(posedge arst_n);
    @(negedge clk);
    for (int n = 0; n < TXN_PER_MST; n++) begin
      r     = '{dat: $urandom, adr: random_addr(), sel: 4'($urandom),
                we: 1'($urandom & 1), cyc: 1'b1, stb: 1'b1};
      t.slv = expected_slave(r.adr);
      t.dat = r.dat;
      t.sel = r.sel;
      t.we  = r.we;
      cur[id]   = t;
      m_req[id] = r;
      issued_cnt[id]++;
      // Hold the request until ack, then through the ack cycle edge
      do @(negedge clk); while (m_ack[id] !== 1'b1);
      @(negedge clk);
      if (n >= BURST_TXN) begin
        m_req[id] = '0;
        repeat ($urandom % 4) @(negedge clk);
      end
    end
    m_req[id] = '0;
    masters_done++;
  endtask

  task automatic serve_slave(input int k);
    txn_t seen;
    int   wait_n;
    s_ack[k]  = 1'b0;
    s_rdat[k] = '0;
    forever begin
      @(negedge clk);
      s_ack[k] = 1'b0;
      if (s_stb[k] === 1'b1) begin
        compare_value($sformatf("s%0d_wbd_cyc_o", k), 32'(s_cyc[k]), 32'h1);
        seen   = slave_view(k);
        wait_n = $urandom % 4;
        // Request must not move while this slave stalls
        repeat (wait_n) begin
          @(negedge clk);
          checks++;
          assert (slave_view(k) === seen) else begin
            $display("error: s%0d request got %h expected %h", k, slave_view(k), seen);
            errors++;
          end
        end
        s_rdat[k] = 32'(k) ^ seen.slv.adr;
        s_ack[k]  = 1'b1;
        slv_log.push_back(seen);
      end
    end
  endtask

  for (genvar g = 0; g < NUM_MST; g++) begin : g_mst
    initial run_master(g);
  end

  for (genvar g = 0; g < NUM_SLV; g++) begin : g_slv
    initial serve_slave(g);
  end

  // --------------------------------------------------------------------
  // Compare process
  // --------------------------------------------------------------------
  task automatic check_completion(input int i);
    txn_t exp;
    txn_t got;
    int   err0;
    err0 = errors;
    check_that(issued_cnt[i] != done_cnt[i],
               $sformatf("m%0d saw an ack with no request outstanding", i));
    if (issued_cnt[i] == done_cnt[i]) begin
      return;
    end
    exp = cur[i];
    check_that(slv_log.size() > 0,
               $sformatf("m%0d got an ack but no slave served its request", i));
    if (slv_log.size() > 0) begin
      got = slv_log.pop_front();
      check_that(got.slv.tid == exp.slv.tid,
                 $sformatf("request for s%0d was served by s%0d", exp.slv.tid, got.slv.tid));
      compare_value($sformatf("s%0d_wbd_adr_o", exp.slv.tid), got.slv.adr, exp.slv.adr);
      compare_value($sformatf("s%0d_wbd_dat_o", exp.slv.tid), got.dat, exp.dat);
      compare_value($sformatf("s%0d_wbd_sel_o", exp.slv.tid), 32'(got.sel), 32'(exp.sel));
      compare_value($sformatf("s%0d_wbd_we_o", exp.slv.tid), 32'(got.we), 32'(exp.we));
    end
    // Read data from the reference slave answer
    compare_value($sformatf("m%0d_wbd_dat_o", i), m_dat[i], 32'(exp.slv.tid) ^ exp.slv.adr);
    if (comp_total < NUM_MST * BURST_TXN) begin
      check_that(i == comp_total % NUM_MST,
                 $sformatf("completion %0d came from m%0d out of round-robin order",
                           comp_total, i));
    end
    // No master twice ahead of one that keeps waiting
    for (int j = 0; j < NUM_MST; j++) begin
      if (j != i && m_req[j].stb && m_ack[j] !== 1'b1) begin
        wins[j][i]++;
        check_that(wins[j][i] < 2,
                   $sformatf("m%0d completed twice while m%0d waited", i, j));
      end
    end
    done_cnt[i]++;
    comp_total++;
    $display("test %0d m%0d %s s%0d adr %h %s", comp_total, i, exp.we ? "write" : "read",
             exp.slv.tid, exp.slv.adr, (errors == err0) ? "ok" : "mismatch");
  endtask

  always @(posedge clk) begin : compare_proc
    int n_ack;
    int n_stb;
    int n_issued;
    n_ack    = 0;
    n_stb    = 0;
    n_issued = 0;
    for (int i = 0; i < NUM_MST; i++) begin
      n_ack    += (m_ack[i] !== 1'b0);
      n_issued += issued_cnt[i];
    end
    for (int k = 0; k < NUM_SLV; k++) begin
      n_stb += (s_stb[k] !== 1'b0);
    end
    // Quiet bus from reset up to the first request
    if (n_issued == 0) begin
      check_that(n_ack == 0 && n_stb == 0, "ack or slave strobe active before any request");
    end
    check_that(n_stb <= 1, "more than one slave strobe active at once");
    check_that(n_ack <= 1, "more than one master ack active at once");
    for (int j = 0; j < NUM_MST; j++) begin
      if (!(m_req[j].stb && m_ack[j] !== 1'b1)) begin
        for (int m = 0; m < NUM_MST; m++) begin
          wins[j][m] = 0;
        end
      end
    end
    for (int i = 0; i < NUM_MST; i++) begin
      if (m_ack[i] === 1'b1) begin
        check_completion(i);
      end
    end
  end

  // Run limit in clock cycles
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles with transfers still open", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------
  // Run control
  // --------------------------------------------------------------------
  initial begin : main
    int unsigned seed_ret;
    seed_ret = $urandom(SEED);
    for (int i = 0; i < NUM_MST; i++) begin
      m_req[i]      = '0;
      cur[i]        = '0;
      issued_cnt[i] = 0;
      done_cnt[i]   = 0;
      for (int j = 0; j < NUM_MST; j++) begin
        wins[i][j] = 0;
      end
    end
    masters_done = 0;
    comp_total   = 0;
    checks       = 0;
    errors       = 0;
    cycles       = 0;
    wait (masters_done == NUM_MST);
    repeat (4) @(negedge clk);
    for (int i = 0; i < NUM_MST; i++) begin
      check_that(done_cnt[i] == TXN_PER_MST,
                 $sformatf("m%0d finished %0d of %0d transfers", i, done_cnt[i], TXN_PER_MST));
    end
    check_that(slv_log.size() == 0, "slaves served transfers that never completed at a master");
    $display("%0d tests, %0d checks, %0d errors", comp_total, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
wbi_pkg.sv
wbi_rr_arb.sv
wbi_master_mux.sv
wbi_addr_decode.sv
wbi_stage.sv
wbi_slave_route.sv
wb_interconnect.sv
tb_clk_gen.sv
tb_wb_interconnect.sv
